// File: Bender.yml
package:
  name: bbc_mem

sources:
  - logic/bbc_mem_pkg.sv
  - logic/bbc_addr_decode.sv
  - logic/bbc_mem_store.sv
  - logic/bbc_read_select.sv
  - logic/bbc_reset_ctrl.sv
  - logic/bbc_mem_top.sv
  - target: test
    files:
      - verification/bbc_mem_chk.sv
      - verification/bbc_mem_tb.sv

// File: files.f
logic/bbc_mem_pkg.sv
logic/bbc_addr_decode.sv
logic/bbc_mem_store.sv
logic/bbc_read_select.sv
logic/bbc_reset_ctrl.sv
logic/bbc_mem_top.sv
verification/bbc_mem_chk.sv
verification/bbc_mem_tb.sv

// File: logic/bbc_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_addr_decode import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic mem_req,
	input wire logic mem_we,
	input wire logic rom_map_low,
	input wire logic [15:0] mem_adr,
	input wire logic [3:0] mem_romsel,
	input wire logic [7:0] mem_do,
	input wire logic loader_active,
	output logic s1_valid,
	output logic s1_we,
	output region_t s1_region,
	output logic [STORE_AW-1:0] s1_store_adr,
	output logic [7:0] s1_data,
	output logic [7:0] s1_lo
);

	region_t region;
	logic [3:0] basic_bank;
	logic [3:0] smmc_bank;
	logic writable;
	logic [STORE_AW-1:0] store_adr;

	// bank numbers move with the mapping option
	assign basic_bank = rom_map_low ? ROMSEL_BASIC_LOW : ROMSEL_BASIC_HIGH;
	assign smmc_bank = rom_map_low ? ROMSEL_SMMC_LOW : ROMSEL_SMMC_HIGH;

	always_comb begin
		if (!mem_adr[15])
			region = REG_CPU_RAM;
		else if (mem_adr[14])
			region = REG_MOS_ROM;
		else if (mem_romsel == basic_bank)
			region = REG_BASIC_ROM;
		else if (mem_romsel == smmc_bank)
			region = REG_SMMC_ROM;
		else if (mem_romsel == ROMSEL_BANK_A)
			region = REG_BANK_A;
		else if (mem_romsel[3:2] == 2'b01)	// banks 4 to 7
			region = REG_SWRAM;
		else
			region = REG_UNMAPPED;
	end

	assign writable = (region == REG_CPU_RAM) || (region == REG_SWRAM);

	// paged accesses land above main ram, one 16k slot per bank
	assign store_adr = (region == REG_CPU_RAM) ?
		{{(STORE_AW-16){1'b0}}, mem_adr} :
		{SWR_PREFIX, mem_romsel, mem_adr[13:0]};

	always_ff @(posedge clk_32m) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_we <= 1'b0;
		end else begin
			// a write that cannot land has nothing left to do
			s1_valid <= mem_req && !loader_active && (!mem_we || writable);
			s1_we <= mem_req && !loader_active && mem_we && writable;
		end
	end

	always_ff @(posedge clk_32m) begin
		s1_region <= region;
		s1_store_adr <= store_adr;
		s1_data <= mem_do;
		s1_lo <= mem_adr[7:0];
	end

endmodule

`default_nettype wire

// File: logic/bbc_mem_pkg.sv
`default_nettype none

package bbc_mem_pkg;

	// memory regions seen by the cpu bus
	typedef enum logic [2:0] {
		REG_CPU_RAM,
		REG_MOS_ROM,
		REG_BASIC_ROM,
		REG_SMMC_ROM,
		REG_SWRAM,
		REG_BANK_A,
		REG_UNMAPPED
	} region_t;

	localparam int STORE_AW = 19;		// byte store address width
	localparam logic SWR_PREFIX = 1'b1;	// bit 18 set for paged accesses

	// bank numbers for the built-in roms, high and low mapping
	localparam logic [3:0] ROMSEL_BASIC_HIGH = 4'd14;
	localparam logic [3:0] ROMSEL_BASIC_LOW = 4'd0;
	localparam logic [3:0] ROMSEL_SMMC_HIGH = 4'd12;
	localparam logic [3:0] ROMSEL_SMMC_LOW = 4'd2;
	localparam logic [3:0] ROMSEL_BANK_A = 4'd10;	// read back from the store

	localparam logic [7:0] OPEN_BUS = 8'hff;

	// tags mixed into the rom stand-in bytes
	localparam logic [7:0] TAG_MOS = 8'h0c;
	localparam logic [7:0] TAG_BASIC = 8'hba;
	localparam logic [7:0] TAG_SMMC = 8'h5d;

	localparam logic [11:0] REMAP_HOLD = 12'd4095;	// reset hold after a map change

	// synthetic rom content in place of the real images
	function automatic logic [7:0] rom_byte(input logic [7:0] lo, input region_t region);
		logic [7:0] tag;
		case (region)
			REG_MOS_ROM: tag = TAG_MOS;
			REG_BASIC_ROM: tag = TAG_BASIC;
			REG_SMMC_ROM: tag = TAG_SMMC;
			default: tag = 8'h00;
		endcase
		return lo ^ tag;
	endfunction

endpackage

`default_nettype wire

// File: logic/bbc_mem_store.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_store import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic s1_valid,
	input wire logic s1_we,
	input wire region_t s1_region,
	input wire logic [STORE_AW-1:0] s1_store_adr,
	input wire logic [7:0] s1_data,
	input wire logic [7:0] s1_lo,
	input wire logic loader_active,
	input wire logic loader_we,
	input wire logic [STORE_AW-1:0] loader_addr,
	input wire logic [7:0] loader_data,
	output logic s2_valid,
	output logic s2_we,
	output region_t s2_region,
	output logic [7:0] s2_rd,
	output logic [7:0] s2_lo
);

	// stands in for the external sdram
	logic [7:0] mem [0:(2**STORE_AW)-1];

	// comes up cleared, like the sdram after its init sequence
	initial begin
		for (int i = 0; i < 2**STORE_AW; i++)
			mem[i] = 8'h00;
	end

	always_ff @(posedge clk_32m) begin
		if (loader_active && loader_we)
			mem[loader_addr] <= loader_data;	// rom download
		else if (s1_valid && s1_we)
			mem[s1_store_adr] <= s1_data;
		s2_rd <= mem[s1_store_adr];	// old byte on a same-cycle write
	end

	always_ff @(posedge clk_32m) begin
		if (reset) begin
			s2_valid <= 1'b0;
			s2_we <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
			s2_we <= s1_we;
		end
	end

	always_ff @(posedge clk_32m) begin
		s2_region <= s1_region;
		s2_lo <= s1_lo;
	end

endmodule

`default_nettype wire

// File: logic/bbc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_top import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic mem_req,
	input wire logic mem_we,
	input wire logic [15:0] mem_adr,
	input wire logic [3:0] mem_romsel,
	input wire logic [7:0] mem_do,
	input wire logic rom_map_low,
	input wire logic mem_sync,
	input wire logic status_reset,
	input wire logic button_reset,
	input wire logic loader_active,
	input wire logic loader_we,
	input wire logic [STORE_AW-1:0] loader_addr,
	input wire logic [7:0] loader_data,
	output logic rd_valid,
	output logic [7:0] rd_data,
	output logic core_reset
);

	// stage 1 to 2
	logic s1_valid;
	logic s1_we;
	region_t s1_region;
	logic [STORE_AW-1:0] s1_store_adr;
	logic [7:0] s1_data;
	logic [7:0] s1_lo;

	// stage 2 to 3
	logic s2_valid;
	logic s2_we;
	region_t s2_region;
	logic [7:0] s2_rd;
	logic [7:0] s2_lo;

	bbc_addr_decode u_decode (
		.clk_32m(clk_32m),
		.reset(reset),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.rom_map_low(rom_map_low),
		.mem_adr(mem_adr),
		.mem_romsel(mem_romsel),
		.mem_do(mem_do),
		.loader_active(loader_active),
		.s1_valid(s1_valid),
		.s1_we(s1_we),
		.s1_region(s1_region),
		.s1_store_adr(s1_store_adr),
		.s1_data(s1_data),
		.s1_lo(s1_lo)
	);

	bbc_mem_store u_store (
		.clk_32m(clk_32m),
		.reset(reset),
		.s1_valid(s1_valid),
		.s1_we(s1_we),
		.s1_region(s1_region),
		.s1_store_adr(s1_store_adr),
		.s1_data(s1_data),
		.s1_lo(s1_lo),
		.loader_active(loader_active),
		.loader_we(loader_we),
		.loader_addr(loader_addr),
		.loader_data(loader_data),
		.s2_valid(s2_valid),
		.s2_we(s2_we),
		.s2_region(s2_region),
		.s2_rd(s2_rd),
		.s2_lo(s2_lo)
	);

	bbc_read_select u_select (
		.clk_32m(clk_32m),
		.reset(reset),
		.s2_valid(s2_valid),
		.s2_we(s2_we),
		.s2_region(s2_region),
		.s2_rd(s2_rd),
		.s2_lo(s2_lo),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	bbc_reset_ctrl u_reset (
		.clk_32m(clk_32m),
		.reset(reset),
		.mem_sync(mem_sync),
		.status_reset(status_reset),
		.button_reset(button_reset),
		.loader_active(loader_active),
		.rom_map_low(rom_map_low),
		.core_reset(core_reset)
	);

endmodule

`default_nettype wire

// File: logic/bbc_read_select.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_read_select import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic s2_valid,
	input wire logic s2_we,
	input wire region_t s2_region,
	input wire logic [7:0] s2_rd,
	input wire logic [7:0] s2_lo,
	output logic rd_valid,
	output logic [7:0] rd_data
);

	logic [7:0] sel_byte;
	logic is_read;

	assign is_read = s2_valid && !s2_we;

	always_comb begin
		case (s2_region)
			REG_MOS_ROM,
			REG_BASIC_ROM,
			REG_SMMC_ROM: sel_byte = rom_byte(s2_lo, s2_region);
			REG_CPU_RAM,
			REG_SWRAM,
			REG_BANK_A: sel_byte = s2_rd;
			default: sel_byte = OPEN_BUS;	// nothing drives the bus
		endcase
	end

	always_ff @(posedge clk_32m) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= is_read;
	end

	// data holds between reads
	always_ff @(posedge clk_32m) begin
		if (is_read)
			rd_data <= sel_byte;
	end

endmodule

`default_nettype wire

// File: logic/bbc_reset_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_reset_ctrl import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic mem_sync,
	input wire logic status_reset,
	input wire logic button_reset,
	input wire logic loader_active,
	input wire logic rom_map_low,
	output logic core_reset
);

	logic last_map;
	logic [11:0] remap_cnt;
	logic reset_src;

	// restart the hold whenever the mapping option flips
	always_ff @(posedge clk_32m) begin
		if (reset) begin
			last_map <= rom_map_low;
			remap_cnt <= REMAP_HOLD;	// hold also runs out of reset
		end else begin
			last_map <= rom_map_low;
			if (last_map != rom_map_low)
				remap_cnt <= REMAP_HOLD;
			else if (remap_cnt != 12'd0)
				remap_cnt <= remap_cnt - 12'd1;
		end
	end

	assign reset_src = status_reset || button_reset || loader_active ||
		(remap_cnt != 12'd0);

	// core reset only moves with the memory cycle
	always_ff @(posedge clk_32m) begin
		if (reset)
			core_reset <= 1'b1;
		else if (mem_sync)
			core_reset <= reset_src;
	end

endmodule

`default_nettype wire

// File: verification/bbc_mem_chk.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_chk import bbc_mem_pkg::*; (
	input wire logic clk_32m,
	input wire logic reset,
	input wire logic mem_req,
	input wire logic mem_we,
	input wire logic loader_active,
	input wire logic rd_valid,
	input wire logic s1_we,
	input wire region_t s1_region
);

	int assert_fails = 0;
	region_t s1_region_seen;

	assign s1_region_seen = s1_region;	// decoded region one cycle after the strobe

	// three stage pipe, no stalls
	a_read_latency: assert property (@(posedge clk_32m) disable iff (reset)
		mem_req && !mem_we && !loader_active |-> ##3 rd_valid)
	else begin
		assert_fails++;
		$error("read strobe not answered three cycles later");
	end

	a_reset_quiet: assert property (@(posedge clk_32m) reset |=> !rd_valid)
	else begin
		assert_fails++;
		$error("rd_valid high right after reset");
	end

	// only main ram and sideways ram take writes
	a_write_region: assert property (@(posedge clk_32m) disable iff (reset)
		s1_we |-> (s1_region == REG_CPU_RAM || s1_region == REG_SWRAM))
	else begin
		assert_fails++;
		$error("write reached the store for a read-only region");
	end

endmodule

`default_nettype wire

// File: verification/bbc_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_tb import bbc_mem_pkg::*; ();

	localparam int SEED = 27111;
	localparam int N_RAM = 300;
	localparam int N_PAGED = 500;
	localparam int N_LOAD = 32;
	localparam int TEST_CYCLES = 3 * int'(REMAP_HOLD) + 2 * (N_RAM + N_PAGED + 2 * N_LOAD) + 200;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + int'(REMAP_HOLD);

	logic clk_32m;
	logic reset;
	logic mem_req;
	logic mem_we;
	logic [15:0] mem_adr;
	logic [3:0] mem_romsel;
	logic [7:0] mem_do;
	logic rom_map_low;
	logic mem_sync;
	logic status_reset;
	logic button_reset;
	logic loader_active;
	logic loader_we;
	logic [STORE_AW-1:0] loader_addr;
	logic [7:0] loader_data;
	logic rd_valid;
	logic [7:0] rd_data;
	logic core_reset;

	logic [15:0] lfsr = 16'(SEED);
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	bit checking = 1'b0;
	logic [7:0] m_mem [0:(2**STORE_AW)-1];	// reference copy of the store
	logic [7:0] rd_q[$];
	int rd_due_q[$];
	region_t rg_q[$];
	int rg_due_q[$];
	logic m_last;
	logic [11:0] m_hold;
	logic m_core;

	bbc_mem_top dut0 (.*);

	bind bbc_mem_top bbc_mem_chk chk0 (
		.clk_32m(clk_32m),
		.reset(reset),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.loader_active(loader_active),
		.rd_valid(rd_valid),
		.s1_we(s1_we),
		.s1_region(s1_region)
	);

	// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] rnd(input int nbits);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic region_t model_region(input logic [15:0] adr, input logic [3:0] sel,
		input logic low);
		if (!adr[15])
			return REG_CPU_RAM;
		if (adr[14])
			return REG_MOS_ROM;
		if (sel == (low ? ROMSEL_BASIC_LOW : ROMSEL_BASIC_HIGH))
			return REG_BASIC_ROM;
		if (sel == (low ? ROMSEL_SMMC_LOW : ROMSEL_SMMC_HIGH))
			return REG_SMMC_ROM;
		if (sel == ROMSEL_BANK_A)
			return REG_BANK_A;
		if (sel[3:2] == 2'b01)
			return REG_SWRAM;
		return REG_UNMAPPED;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, act, exp);
		end
	endtask

	task automatic check_region(input string name, input region_t act, input region_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
		end
	endtask

	// one cpu strobe, model updated in issue order
	task automatic issue(input logic we, input logic [15:0] adr, input logic [3:0] sel,
		input logic [7:0] dat);
		region_t rg;
		logic [STORE_AW-1:0] sa;
		logic [7:0] exp;
		@(posedge clk_32m);
		rg = model_region(adr, sel, rom_map_low);
		sa = (rg == REG_CPU_RAM) ? {{(STORE_AW-16){1'b0}}, adr} : {SWR_PREFIX, sel, adr[13:0]};
		mem_req <= 1'b1;
		mem_we <= we;
		mem_adr <= adr;
		mem_romsel <= sel;
		mem_do <= dat;
		// cyc has not yet counted this edge, the dut samples the strobe one edge on
		rg_q.push_back(rg);
		rg_due_q.push_back(cyc + 2);
		if (we && (rg == REG_CPU_RAM || rg == REG_SWRAM)) begin
			m_mem[sa] = dat;
		end else if (!we) begin
			case (rg)
				REG_MOS_ROM: exp = adr[7:0] ^ TAG_MOS;
				REG_BASIC_ROM: exp = adr[7:0] ^ TAG_BASIC;
				REG_SMMC_ROM: exp = adr[7:0] ^ TAG_SMMC;
				REG_UNMAPPED: exp = OPEN_BUS;
				default: exp = m_mem[sa];
			endcase
			rd_q.push_back(exp);
			rd_due_q.push_back(cyc + 4);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_32m);
			mem_req <= 1'b0;
		end
	endtask

	task automatic set_map(input logic low);
		@(posedge clk_32m);
		mem_req <= 1'b0;
		rom_map_low <= low;
	endtask

	task automatic wait_core(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk_32m);
		while (core_reset !== level && n < limit) begin
			@(negedge clk_32m);
			n++;
		end
		if (core_reset !== level) begin
			errors++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		if (errors == err0)
			$display("test %s: pass", name);
		else
			$display("test %s: fail, %0d errors", name, errors - err0);
	endtask

	initial begin
		clk_32m = 1'b0;
		forever #5 clk_32m = ~clk_32m;
	end

	initial begin
		mem_sync = 1'b0;
		forever begin
			repeat (3) @(posedge clk_32m);
			mem_sync <= 1'b1;	// one in four cycles
			@(posedge clk_32m);
			mem_sync <= 1'b0;
		end
	end

	always @(posedge clk_32m) cyc <= cyc + 1;

	// reset conditioner reference, sees the inputs the dut samples on this edge
	always @(posedge clk_32m) begin
		if (reset) begin
			m_last = rom_map_low;
			m_hold = REMAP_HOLD;
			m_core = 1'b1;
		end else begin
			if (mem_sync)
				m_core = status_reset || button_reset || loader_active || (m_hold != 12'd0);
			if (m_last != rom_map_low)
				m_hold = REMAP_HOLD;
			else if (m_hold != 12'd0)
				m_hold = m_hold - 12'd1;
			m_last = rom_map_low;
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clk_32m) begin
		if (checking) begin
			check_bit("core_reset", core_reset, m_core);
			if (rd_due_q.size() != 0 && rd_due_q[0] == cyc) begin
				check_bit("rd_valid", rd_valid, 1'b1);
				check_byte("rd_data", rd_data, rd_q.pop_front());
				void'(rd_due_q.pop_front());
			end else begin
				check_bit("rd_valid", rd_valid, 1'b0);
			end
			if (rg_due_q.size() != 0 && rg_due_q[0] == cyc) begin
				check_region("s1_region", dut0.chk0.s1_region_seen, rg_q.pop_front());
				void'(rg_due_q.pop_front());
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_32m);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int err0;
		int total;
		logic [7:0] lo;
		logic [STORE_AW-1:0] la;
		for (int i = 0; i < 2**STORE_AW; i++)
			m_mem[i] = 8'h00;
		reset = 1'b1;
		mem_req = 1'b0;
		mem_we = 1'b0;
		mem_adr = 16'h0000;
		mem_romsel = 4'h0;
		mem_do = 8'h00;
		rom_map_low = 1'b0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		loader_active = 1'b0;
		loader_we = 1'b0;
		loader_addr = '0;
		loader_data = 8'h00;
		repeat (4) @(posedge clk_32m);
		reset <= 1'b0;
		checking = 1'b1;

		err0 = errors;
		wait_core(1'b0, int'(REMAP_HOLD) + 20, "core_reset never released after reset");
		finish_test("1 reset release", err0);

		err0 = errors;
		for (int i = 0; i < N_RAM; i++) begin
			if (rnd(2) == 32'd0)
				idle(1);
			else
				issue(1'(rnd(1)), {1'b0, 9'h0a5, 6'(rnd(6))}, 4'(rnd(4)), 8'(rnd(8)));
		end
		idle(4);
		finish_test("2 cpu ram", err0);

		err0 = errors;
		for (int i = 0; i < N_PAGED; i++) begin
			if (i == N_PAGED / 2)
				set_map(1'b1);	// second half under low mapping
			lo = 8'(rnd(6));
			issue(1'(rnd(1)), {1'b1, rnd(2) == 32'd0, 6'h13, lo}, 4'(rnd(4)), 8'(rnd(8)));
		end
		idle(4);
		finish_test("3 paged decode", err0);

		err0 = errors;
		@(posedge clk_32m);
		loader_active <= 1'b1;
		for (int i = 0; i < N_LOAD; i++) begin
			la = {SWR_PREFIX, ROMSEL_BANK_A, 14'h0200 + 14'(i)};
			lo = 8'(rnd(8));
			@(posedge clk_32m);
			loader_we <= 1'b1;
			loader_addr <= la;
			loader_data <= lo;
			mem_req <= (i % 4 == 1);	// must be dropped
			mem_we <= 1'b0;
			mem_adr <= {2'b10, 14'h0200 + 14'(i)};
			mem_romsel <= ROMSEL_BANK_A;
			m_mem[la] = lo;
		end
		@(posedge clk_32m);
		loader_we <= 1'b0;
		loader_active <= 1'b0;
		mem_req <= 1'b0;
		idle(2);
		for (int i = 0; i < N_LOAD; i++)
			issue(1'b0, {2'b10, 14'h0200 + 14'(i)}, ROMSEL_BANK_A, 8'h00);
		idle(4);
		finish_test("4 loader", err0);

		err0 = errors;
		wait_core(1'b0, int'(REMAP_HOLD) + 20, "core_reset still held before the map change");
		set_map(~rom_map_low);
		wait_core(1'b1, 12, "core_reset did not rise after the map change");
		wait_core(1'b0, int'(REMAP_HOLD) + 20, "core_reset did not fall after the remap hold");
		@(posedge clk_32m);
		status_reset <= 1'b1;
		wait_core(1'b1, 12, "status_reset did not raise core_reset");
		@(posedge clk_32m);
		status_reset <= 1'b0;
		wait_core(1'b0, 12, "core_reset stuck after status_reset fell");
		@(posedge clk_32m);
		button_reset <= 1'b1;
		wait_core(1'b1, 12, "button_reset did not raise core_reset");
		@(posedge clk_32m);
		button_reset <= 1'b0;
		wait_core(1'b0, 12, "core_reset stuck after button_reset fell");
		finish_test("5 reset sources", err0);

		total = errors + dut0.chk0.assert_fails;
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut0.chk0.assert_fails);
		if (total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
